/* flist.f */
rtl/cpu_pkg.sv
rtl/cpu_regfile.sv
rtl/cpu_alu.sv
rtl/cpu_decode.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
test/cpu_tb_asserts.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module cpu_tb --Mdir obj_dir -o Vcpu_tb

./obj_dir/Vcpu_tb +verilator+error+limit+100 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

/* test/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	localparam logic [15:0] prog_base = 16'h4000;
	localparam int clk_period_ns = 4;
	localparam int max_instructions = 40;
	localparam int cycles_per_instruction = 10;

	logic clk = 1'b0;
	logic reset;
	logic imem_valid;
	logic imem_ready;
	logic [15:0] imem_addr;
	logic [23:0] imem_rdata;
	logic dmem_valid;
	logic dmem_ready;
	logic dmem_write;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic [1:0] dmem_be;
	logic [15:0] dmem_rdata;
	logic trap;

	logic [7:0] imem [0:255];
	logic [15:0] dmem [0:1023];
	logic [7:0] load_ptr;
	logic [15:0] fetch_off;
	logic [31:0] lfsr_state = 32'h64b0_7450;
	int imem_stall = 0;
	int dmem_stall = 0;
	int store_idx = 0;

	logic [15:0] exp_addr [$];
	logic [1:0] exp_be [$];
	logic [15:0] exp_data [$];

	cpu_top #(
		.reset_vector(prog_base)
	) uut (
		.clk(clk),
		.reset(reset),
		.imem_valid(imem_valid),
		.imem_ready(imem_ready),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_valid(dmem_valid),
		.dmem_ready(dmem_ready),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_be(dmem_be),
		.dmem_rdata(dmem_rdata),
		.trap(trap)
	);

	initial
	begin
		forever #(clk_period_ns / 2) clk = ~clk;
	end

	// galois form, one step per bit
	function automatic logic next_lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'hd000_0001;
		return b;
	endfunction

	task automatic end_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_error(input string why);
		$display("ERROR: %s", why);
		end_with_failure();
	endtask

	task automatic report_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
		end_with_failure();
	endtask

	task automatic put_byte(input logic [7:0] b);
		imem[load_ptr] = b;
		load_ptr = load_ptr + 8'd1;
	endtask

	task automatic two_byte(input logic [7:0] op, input logic [7:0] b);
		put_byte(op);
		put_byte(b);
	endtask

	task automatic three_byte(input logic [7:0] op, input logic [15:0] w);
		put_byte(op);
		put_byte(w[7:0]);
		put_byte(w[15:8]);
	endtask

	task automatic expect_store(input logic [15:0] addr, input logic [1:0] be,
		input logic [15:0] data);
		exp_addr.push_back(addr);
		exp_be.push_back(be);
		exp_data.push_back(data);
	endtask

	task automatic load_program();
		load_ptr = 8'h00;
		// 5a + 33 = 8d
		two_byte(cpu_pkg::OP_LD_XL_IMMD, 8'h5a);
		two_byte(cpu_pkg::OP_ADD_XL_IMMD, 8'h33);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0100);
		// 1234 + f00f wraps to 0243
		three_byte(cpu_pkg::OP_LDW_Y_IMMD, 16'h1234);
		three_byte(cpu_pkg::OP_ADDW_Y_IMMD, 16'hf00f);
		three_byte(cpu_pkg::OP_LDW_DIR_Y, 16'h0102);
		put_byte(cpu_pkg::OP_LDW_X_Y);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0104);
		// compare equal, so jrz skips the ee store
		two_byte(cpu_pkg::OP_LD_XL_IMMD, 8'h8d);
		two_byte(cpu_pkg::OP_CP_XL_IMMD, 8'h8d);
		two_byte(cpu_pkg::OP_JRZ_D, 8'h05);
		two_byte(cpu_pkg::OP_LD_XL_IMMD, 8'hee);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0200);
		// taken jrnz would skip the 0108 store
		two_byte(cpu_pkg::OP_JRNZ_D, 8'h03);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0108);
		// 8d - ff borrows, 8e left in xl
		two_byte(cpu_pkg::OP_SUB_XL_IMMD, 8'hff);
		two_byte(cpu_pkg::OP_JRC_D, 8'h05);
		two_byte(cpu_pkg::OP_LD_XL_IMMD, 8'hee);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0200);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h010a);
		// c3 from memory through xor, and, or
		three_byte(cpu_pkg::OP_LD_XL_DIR, 16'h0300);
		two_byte(cpu_pkg::OP_XOR_XL_IMMD, 8'hff);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0106);
		two_byte(cpu_pkg::OP_AND_XL_IMMD, 8'h0f);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h010c);
		two_byte(cpu_pkg::OP_OR_XL_IMMD, 8'ha0);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h010e);
		three_byte(cpu_pkg::OP_LDW_Y_DIR, 16'h0300);
		three_byte(cpu_pkg::OP_LDW_DIR_Y, 16'h0110);
		three_byte(cpu_pkg::OP_JP_IMMD, 16'h4050);
		two_byte(cpu_pkg::OP_LD_XL_IMMD, 8'hee);
		three_byte(cpu_pkg::OP_LD_DIR_XL, 16'h0200);
		put_byte(cpu_pkg::OP_TRAP);
	endtask

	initial
	begin
		reset = 1'b1;
		imem_ready = 1'b0;
		imem_rdata = '0;
		dmem_ready = 1'b0;
		dmem_rdata = '0;
		for (int i = 0; i < 256; i++)
			imem[i] = 8'(i) ^ 8'h3c;
		for (int i = 0; i < 1024; i++)
			dmem[i] = 16'(i) ^ 16'h5aa5;
		dmem[10'h180] = 16'h00c3;
		load_program();
		expect_store(16'h0100, 2'b01, 16'h008d);
		expect_store(16'h0102, 2'b11, 16'h0243);
		expect_store(16'h0104, 2'b01, 16'h0043);
		expect_store(16'h0108, 2'b01, 16'h008d);
		expect_store(16'h010a, 2'b01, 16'h008e);
		expect_store(16'h0106, 2'b01, 16'h003c);
		expect_store(16'h010c, 2'b01, 16'h000c);
		expect_store(16'h010e, 2'b01, 16'h00ac);
		expect_store(16'h0110, 2'b11, 16'h00c3);
		repeat (10) @(negedge clk);
		reset = 1'b0;
		while (trap !== 1'b1)
			@(negedge clk);
		// a few halted cycles for the halt properties
		repeat (4) @(negedge clk);
		if (store_idx != exp_addr.size())
			report_error("core halted before all expected stores were made");
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	assign fetch_off = imem_addr - prog_base;

	// ready with random stalls, at most three in a row
	always @(negedge clk)
	begin
		if (imem_valid && !imem_ready)
			imem_stall = imem_stall + 1;
		else
			imem_stall = 0;
		if (dmem_valid && !dmem_ready)
			dmem_stall = dmem_stall + 1;
		else
			dmem_stall = 0;
		if (imem_stall >= 3)
			imem_ready = 1'b1;
		else
			imem_ready = next_lfsr_bit();
		if (dmem_stall >= 3)
			dmem_ready = 1'b1;
		else
			dmem_ready = next_lfsr_bit();
		imem_rdata = {imem[fetch_off[7:0] + 8'd2], imem[fetch_off[7:0] + 8'd1],
			imem[fetch_off[7:0]]};
		dmem_rdata = dmem[dmem_addr[10:1]];
	end

	always @(posedge clk)
	begin
		if (!reset && dmem_valid && dmem_ready && dmem_write)
		begin
			if (store_idx >= exp_addr.size())
				report_error($sformatf("extra store to %h", dmem_addr));
			else
			begin
				assert (dmem_addr == exp_addr[store_idx])
				else
					report_value("dmem_addr", dmem_addr, exp_addr[store_idx]);
				assert (dmem_be == exp_be[store_idx])
				else
					report_value("dmem_be", {14'd0, dmem_be}, {14'd0, exp_be[store_idx]});
				assert (dmem_wdata == exp_data[store_idx])
				else
					report_value("dmem_wdata", dmem_wdata, exp_data[store_idx]);
				if (dmem_be[0])
					dmem[dmem_addr[10:1]][7:0] = dmem_wdata[7:0];
				if (dmem_be[1])
					dmem[dmem_addr[10:1]][15:8] = dmem_wdata[15:8];
				store_idx = store_idx + 1;
			end
		end
	end

	always @(negedge clk)
	begin
		if (uut.u_asserts.fail_seen)
			report_error("a bus protocol or halt property failed");
	end

	initial
	begin
		#(max_instructions * cycles_per_instruction * clk_period_ns);
		report_error("watchdog expired before the core halted");
	end

endmodule

/* test/cpu_tb_asserts.sv */
`timescale 1ns/1ps

module cpu_tb_asserts (
	input logic clk,
	input logic reset,
	input logic imem_valid,
	input logic imem_ready,
	input logic [15:0] imem_addr,
	input logic dmem_valid,
	input logic dmem_ready,
	input logic dmem_write,
	input logic [15:0] dmem_addr,
	input logic [15:0] dmem_wdata,
	input logic [1:0] dmem_be,
	input logic trap
);

	// raised by any failing property, watched from the testbench top
	logic fail_seen = 1'b0;

	imem_hold: assert property (@(posedge clk) disable iff (reset)
		imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr))
	else
	begin
		fail_seen = 1'b1;
		$error("imem request dropped or address changed before ready");
	end

	dmem_hold: assert property (@(posedge clk) disable iff (reset)
		dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr) &&
			$stable(dmem_write) && (!dmem_write || ($stable(dmem_wdata) && $stable(dmem_be))))
	else
	begin
		fail_seen = 1'b1;
		$error("dmem request dropped or changed before ready");
	end

	// one bus request at a time
	one_request: assert property (@(posedge clk) disable iff (reset)
		!(imem_valid && dmem_valid))
	else
	begin
		fail_seen = 1'b1;
		$error("imem and dmem requests valid in the same cycle");
	end

	quiet_in_reset: assert property (@(posedge clk)
		reset |=> !imem_valid && !dmem_valid && !trap)
	else
	begin
		fail_seen = 1'b1;
		$error("request or trap high while in reset");
	end

	halt_quiet: assert property (@(posedge clk) disable iff (reset)
		trap |-> !imem_valid && !dmem_valid)
	else
	begin
		fail_seen = 1'b1;
		$error("bus request made after the core halted");
	end

	halt_sticky: assert property (@(posedge clk) disable iff (reset)
		trap |=> trap)
	else
	begin
		fail_seen = 1'b1;
		$error("trap fell without a reset");
	end

endmodule

bind cpu_top cpu_tb_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.imem_valid(imem_valid),
	.imem_ready(imem_ready),
	.imem_addr(imem_addr),
	.dmem_valid(dmem_valid),
	.dmem_ready(dmem_ready),
	.dmem_write(dmem_write),
	.dmem_addr(dmem_addr),
	.dmem_wdata(dmem_wdata),
	.dmem_be(dmem_be),
	.trap(trap)
);

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter logic [15:0] reset_vector = 16'h4000
) (
	input logic clk,
	input logic reset,
	output logic imem_valid,
	input logic imem_ready,
	output logic [15:0] imem_addr,
	input logic [cpu_pkg::INST_W-1:0] imem_rdata,
	output logic dmem_valid,
	input logic dmem_ready,
	output logic dmem_write,
	output logic [15:0] dmem_addr,
	output logic [cpu_pkg::DATA_W-1:0] dmem_wdata,
	output logic [1:0] dmem_be,
	input logic [cpu_pkg::DATA_W-1:0] dmem_rdata,
	output logic trap
);

	logic [cpu_pkg::DATA_W-1:0] x, y;
	logic [cpu_pkg::DATA_W-1:0] alu_a, alu_b, alu_result;
	logic alu_carry, alu_zero, alu_negative;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::wb_sel_t wr_addr;
	logic [1:0] wr_be;
	logic [cpu_pkg::DATA_W-1:0] wr_data;

	cpu_control #(
		.reset_vector(reset_vector)
	) u_control (
		.clk(clk),
		.reset(reset),
		.imem_valid(imem_valid),
		.imem_ready(imem_ready),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_valid(dmem_valid),
		.dmem_ready(dmem_ready),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_be(dmem_be),
		.dmem_rdata(dmem_rdata),
		.trap(trap),
		.x(x),
		.y(y),
		.alu_result(alu_result),
		.alu_carry(alu_carry),
		.alu_zero(alu_zero),
		.alu_negative(alu_negative),
		.alu_op_o(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.wr_addr(wr_addr),
		.wr_be(wr_be),
		.wr_data(wr_data)
	);

	// z is not read by any kept instruction
	cpu_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.wr_addr(wr_addr),
		.wr_be(wr_be),
		.wr_data(wr_data),
		.x(x),
		.y(y),
		.z()
	);

	cpu_alu u_alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result),
		.carry(alu_carry),
		.zero(alu_zero),
		.negative(alu_negative)
	);

endmodule

/* rtl/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control #(
	parameter logic [15:0] reset_vector = 16'h4000
) (
	input logic clk,
	input logic reset,
	output logic imem_valid,
	input logic imem_ready,
	output logic [15:0] imem_addr,
	input logic [cpu_pkg::INST_W-1:0] imem_rdata,
	output logic dmem_valid,
	input logic dmem_ready,
	output logic dmem_write,
	output logic [15:0] dmem_addr,
	output logic [cpu_pkg::DATA_W-1:0] dmem_wdata,
	output logic [1:0] dmem_be,
	input logic [cpu_pkg::DATA_W-1:0] dmem_rdata,
	output logic trap,
	input logic [cpu_pkg::DATA_W-1:0] x,
	input logic [cpu_pkg::DATA_W-1:0] y,
	input logic [cpu_pkg::DATA_W-1:0] alu_result,
	input logic alu_carry,
	input logic alu_zero,
	input logic alu_negative,
	output cpu_pkg::alu_op_t alu_op_o,
	output logic [cpu_pkg::DATA_W-1:0] alu_a,
	output logic [cpu_pkg::DATA_W-1:0] alu_b,
	output cpu_pkg::wb_sel_t wr_addr,
	output logic [1:0] wr_be,
	output logic [cpu_pkg::DATA_W-1:0] wr_data
);

	cpu_pkg::state_t state, next_state;
	logic [cpu_pkg::INST_W-1:0] inst;
	logic [15:0] pc, next_pc;
	logic [2:0] flags;
	logic taken;
	logic fetch_done, mem_done, exec_wb;

	cpu_pkg::alu_op_t alu_op;
	logic operand_imm, word_access, is_jump, is_trap;
	cpu_pkg::wb_sel_t wb_sel;
	cpu_pkg::mem_op_t mem_op;
	logic [2:0] upd_flags;
	logic [1:0] branch_cond, length;

	cpu_decode u_decode (
		.opcode(cpu_pkg::opcode_t'(inst[7:0])),
		.alu_op(alu_op),
		.operand_imm(operand_imm),
		.wb_sel(wb_sel),
		.mem_op(mem_op),
		.word_access(word_access),
		.upd_flags(upd_flags),
		.branch_cond(branch_cond),
		.is_jump(is_jump),
		.is_trap(is_trap),
		.length(length)
	);

	assign fetch_done = imem_valid && imem_ready;
	assign mem_done = dmem_valid && dmem_ready;

	always_comb
	begin
		next_state = state;
		case (state)
			cpu_pkg::ST_FETCH:
				if (fetch_done)
					next_state = cpu_pkg::ST_EXEC;
			cpu_pkg::ST_EXEC:
				if (is_trap)
					next_state = cpu_pkg::ST_HALT;
				else if (mem_op != cpu_pkg::MEM_NONE)
					next_state = cpu_pkg::ST_MEM;
				else
					next_state = cpu_pkg::ST_FETCH;
			cpu_pkg::ST_MEM:
				if (mem_done)
					next_state = cpu_pkg::ST_FETCH;
			default:
				next_state = cpu_pkg::ST_HALT;
		endcase
	end

	always_comb
	begin
		case (branch_cond)
			2'd0: taken = 1'b1;
			2'd1: taken = flags[cpu_pkg::FLAG_Z];
			2'd2: taken = !flags[cpu_pkg::FLAG_Z];
			default: taken = flags[cpu_pkg::FLAG_C];
		endcase
		// absolute jump is the only 3-byte jump
		if (is_jump && length == cpu_pkg::LEN_3)
			next_pc = inst[23:8];
		else if (is_jump && taken)
			next_pc = pc + 16'd2 + {{8{inst[15]}}, inst[15:8]};
		else
			next_pc = pc + {14'd0, length};
	end

	// request lines registered so they stay low through reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= cpu_pkg::ST_FETCH;
			pc <= reset_vector;
			flags <= 3'b000;
			imem_valid <= 1'b0;
			dmem_valid <= 1'b0;
			trap <= 1'b0;
		end
		else
		begin
			state <= next_state;
			imem_valid <= (next_state == cpu_pkg::ST_FETCH);
			dmem_valid <= (next_state == cpu_pkg::ST_MEM);
			trap <= (next_state == cpu_pkg::ST_HALT);
			if (state == cpu_pkg::ST_EXEC)
			begin
				pc <= next_pc;
				if (upd_flags[cpu_pkg::FLAG_C])
					flags[cpu_pkg::FLAG_C] <= alu_carry;
				if (upd_flags[cpu_pkg::FLAG_Z])
					flags[cpu_pkg::FLAG_Z] <= alu_zero;
				if (upd_flags[cpu_pkg::FLAG_N])
					flags[cpu_pkg::FLAG_N] <= alu_negative;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == cpu_pkg::ST_FETCH && fetch_done)
			inst <= imem_rdata;
	end

	assign imem_addr = pc;

	assign dmem_write = (mem_op == cpu_pkg::MEM_WRITE);
	assign dmem_addr = inst[23:8];
	assign dmem_be = word_access ? 2'b11 : 2'b01;
	assign dmem_wdata = word_access ? y : {8'h00, x[7:0]};

	assign alu_op_o = alu_op;
	assign alu_a = (alu_op == cpu_pkg::ALU_ADDW) ? y : x;
	assign alu_b = operand_imm ? inst[23:8] : y;

	// register ops write in exec, loads at the dmem handshake
	assign exec_wb = (state == cpu_pkg::ST_EXEC) && (mem_op == cpu_pkg::MEM_NONE);
	always_comb
	begin
		if (exec_wb || (state == cpu_pkg::ST_MEM && mem_done && mem_op == cpu_pkg::MEM_READ))
			wr_addr = wb_sel;
		else
			wr_addr = cpu_pkg::WB_NONE;
		case (wr_addr)
			cpu_pkg::WB_XL: wr_be = 2'b01;
			cpu_pkg::WB_NONE: wr_be = 2'b00;
			default: wr_be = 2'b11;
		endcase
	end

	assign wr_data = (state == cpu_pkg::ST_MEM) ? dmem_rdata : alu_result;

endmodule

/* rtl/cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode (
	input cpu_pkg::opcode_t opcode,
	output cpu_pkg::alu_op_t alu_op,
	output logic operand_imm,
	output cpu_pkg::wb_sel_t wb_sel,
	output cpu_pkg::mem_op_t mem_op,
	output logic word_access,
	output logic [2:0] upd_flags,
	output logic [1:0] branch_cond,
	output logic is_jump,
	output logic is_trap,
	output logic [1:0] length
);

	logic arith;
	logic logic_op;

	// flags touched by each class of ALU op
	assign arith = (opcode == cpu_pkg::OP_ADD_XL_IMMD) || (opcode == cpu_pkg::OP_SUB_XL_IMMD) ||
		(opcode == cpu_pkg::OP_CP_XL_IMMD) || (opcode == cpu_pkg::OP_ADDW_Y_IMMD);
	assign logic_op = (opcode == cpu_pkg::OP_AND_XL_IMMD) || (opcode == cpu_pkg::OP_OR_XL_IMMD) ||
		(opcode == cpu_pkg::OP_XOR_XL_IMMD);

	always_comb
	begin
		upd_flags = 3'b000;
		upd_flags[cpu_pkg::FLAG_C] = arith;
		upd_flags[cpu_pkg::FLAG_Z] = arith || logic_op;
		upd_flags[cpu_pkg::FLAG_N] = arith || logic_op;
	end

	always_comb
	begin
		alu_op = cpu_pkg::ALU_PASS;
		operand_imm = 1'b1;
		wb_sel = cpu_pkg::WB_NONE;
		mem_op = cpu_pkg::MEM_NONE;
		word_access = 1'b0;
		// 0 always, 1 zero, 2 not zero, 3 carry
		branch_cond = 2'd0;
		is_jump = 1'b0;
		is_trap = 1'b0;
		length = cpu_pkg::LEN_1;
		case (opcode)
			cpu_pkg::OP_LD_XL_IMMD:
			begin
				wb_sel = cpu_pkg::WB_XL;
				length = cpu_pkg::LEN_2;
			end
			cpu_pkg::OP_LDW_Y_IMMD:
			begin
				wb_sel = cpu_pkg::WB_Y;
				length = cpu_pkg::LEN_3;
			end
			cpu_pkg::OP_ADD_XL_IMMD, cpu_pkg::OP_SUB_XL_IMMD, cpu_pkg::OP_AND_XL_IMMD,
			cpu_pkg::OP_OR_XL_IMMD, cpu_pkg::OP_XOR_XL_IMMD, cpu_pkg::OP_CP_XL_IMMD:
			begin
				case (opcode)
					cpu_pkg::OP_ADD_XL_IMMD: alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::OP_AND_XL_IMMD: alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::OP_OR_XL_IMMD: alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::OP_XOR_XL_IMMD: alu_op = cpu_pkg::ALU_XOR;
					default: alu_op = cpu_pkg::ALU_SUB;
				endcase
				// compare keeps xl
				wb_sel = (opcode == cpu_pkg::OP_CP_XL_IMMD) ? cpu_pkg::WB_NONE : cpu_pkg::WB_XL;
				length = cpu_pkg::LEN_2;
			end
			cpu_pkg::OP_ADDW_Y_IMMD:
			begin
				alu_op = cpu_pkg::ALU_ADDW;
				wb_sel = cpu_pkg::WB_Y;
				length = cpu_pkg::LEN_3;
			end
			cpu_pkg::OP_LD_XL_DIR, cpu_pkg::OP_LDW_Y_DIR:
			begin
				mem_op = cpu_pkg::MEM_READ;
				word_access = (opcode == cpu_pkg::OP_LDW_Y_DIR);
				wb_sel = word_access ? cpu_pkg::WB_Y : cpu_pkg::WB_XL;
				length = cpu_pkg::LEN_3;
			end
			cpu_pkg::OP_LD_DIR_XL, cpu_pkg::OP_LDW_DIR_Y:
			begin
				mem_op = cpu_pkg::MEM_WRITE;
				word_access = (opcode == cpu_pkg::OP_LDW_DIR_Y);
				length = cpu_pkg::LEN_3;
			end
			cpu_pkg::OP_LDW_X_Y:
			begin
				operand_imm = 1'b0;
				wb_sel = cpu_pkg::WB_X;
			end
			cpu_pkg::OP_JP_IMMD:
			begin
				is_jump = 1'b1;
				length = cpu_pkg::LEN_3;
			end
			cpu_pkg::OP_JR_D, cpu_pkg::OP_JRZ_D, cpu_pkg::OP_JRNZ_D, cpu_pkg::OP_JRC_D:
			begin
				is_jump = 1'b1;
				branch_cond = opcode[1:0] - 2'd1;
				length = cpu_pkg::LEN_2;
			end
			cpu_pkg::OP_TRAP:
				is_trap = 1'b1;
			default:
				length = cpu_pkg::LEN_1;
		endcase
	end

endmodule

/* rtl/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu (
	input cpu_pkg::alu_op_t op,
	input logic [cpu_pkg::DATA_W-1:0] a,
	input logic [cpu_pkg::DATA_W-1:0] b,
	output logic [cpu_pkg::DATA_W-1:0] result,
	output logic carry,
	output logic zero,
	output logic negative
);

	logic [8:0] sum8;
	logic [8:0] diff8;
	logic [16:0] sum16;
	logic wide;

	assign sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]};
	// bit 8 is the borrow, set when a < b unsigned
	assign diff8 = {1'b0, a[7:0]} - {1'b0, b[7:0]};
	assign sum16 = {1'b0, a} + {1'b0, b};

	// 16-bit ops take flags from the full result
	assign wide = (op == cpu_pkg::ALU_ADDW) || (op == cpu_pkg::ALU_PASS);

	always_comb
	begin
		result = '0;
		carry = 1'b0;
		case (op)
			cpu_pkg::ALU_ADD:
			begin
				result = {8'h00, sum8[7:0]};
				carry = sum8[8];
			end
			cpu_pkg::ALU_SUB:
			begin
				result = {8'h00, diff8[7:0]};
				carry = diff8[8];
			end
			cpu_pkg::ALU_AND:
				result = {8'h00, a[7:0] & b[7:0]};
			cpu_pkg::ALU_OR:
				result = {8'h00, a[7:0] | b[7:0]};
			cpu_pkg::ALU_XOR:
				result = {8'h00, a[7:0] ^ b[7:0]};
			cpu_pkg::ALU_ADDW:
			begin
				result = sum16[15:0];
				carry = sum16[16];
			end
			default:
				result = b;
		endcase
	end

	always_comb
	begin
		if (wide)
		begin
			zero = (result == 16'h0000);
			negative = result[15];
		end
		else
		begin
			zero = (result[7:0] == 8'h00);
			negative = result[7];
		end
	end

endmodule

/* rtl/cpu_regfile.sv */
`timescale 1ns/1ps

module cpu_regfile (
	input logic clk,
	input logic reset,
	input cpu_pkg::wb_sel_t wr_addr,
	input logic [1:0] wr_be,
	input logic [cpu_pkg::DATA_W-1:0] wr_data,
	output logic [cpu_pkg::DATA_W-1:0] x,
	output logic [cpu_pkg::DATA_W-1:0] y,
	output logic [cpu_pkg::DATA_W-1:0] z
);

	logic [cpu_pkg::DATA_W-1:0] regs [2];
	logic [1:0] sel;

	// xl and x share register 0
	assign sel[0] = (wr_addr == cpu_pkg::WB_XL) || (wr_addr == cpu_pkg::WB_X);
	assign sel[1] = (wr_addr == cpu_pkg::WB_Y);

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (reset)
				regs[i] <= '0;
			else if (sel[i])
			begin
				if (wr_be[0])
					regs[i][7:0] <= wr_data[7:0];
				if (wr_be[1])
					regs[i][15:8] <= wr_data[15:8];
			end
		end
	end

	assign x = regs[0];
	assign y = regs[1];
	// no write-back target reaches z
	assign z = '0;

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	localparam int INST_W = 24;
	localparam int DATA_W = 16;

	// bit positions in the flags word
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;

	// instruction lengths in bytes
	localparam logic [1:0] LEN_1 = 2'd1;
	localparam logic [1:0] LEN_2 = 2'd2;
	localparam logic [1:0] LEN_3 = 2'd3;

	typedef enum logic [7:0] {
		OP_NOP         = 8'h00,
		OP_LD_XL_IMMD  = 8'h10,
		OP_LDW_Y_IMMD  = 8'h11,
		OP_ADD_XL_IMMD = 8'h20,
		OP_SUB_XL_IMMD = 8'h21,
		OP_AND_XL_IMMD = 8'h22,
		OP_OR_XL_IMMD  = 8'h23,
		OP_XOR_XL_IMMD = 8'h24,
		OP_CP_XL_IMMD  = 8'h25,
		OP_ADDW_Y_IMMD = 8'h28,
		OP_LD_XL_DIR   = 8'h30,
		OP_LDW_Y_DIR   = 8'h31,
		OP_LD_DIR_XL   = 8'h32,
		OP_LDW_DIR_Y   = 8'h33,
		OP_LDW_X_Y     = 8'h40,
		OP_JP_IMMD     = 8'h50,
		OP_JR_D        = 8'h51,
		OP_JRZ_D       = 8'h52,
		OP_JRNZ_D      = 8'h53,
		OP_JRC_D       = 8'h54,
		OP_TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_ADDW
	} alu_op_t;

	typedef enum logic [1:0] {MEM_NONE, MEM_READ, MEM_WRITE} mem_op_t;

	typedef enum logic [1:0] {WB_NONE, WB_XL, WB_Y, WB_X} wb_sel_t;

	typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM, ST_HALT} state_t;

endpackage
